// File: ifq_settings.svh
`ifndef IFQ_SETTINGS_SVH
`define IFQ_SETTINGS_SVH

// queue geometry

// ring entries, power of two so pointers wrap for free
`define IFQ_DEPTH 16

// ring index width, log2 of the depth
`define IFQ_PTR_W 4

// occupancy width
// one bit wider than the pointer so a full ring of 16 fits
`define IFQ_CNT_W 5

// issue statistics

// master and slave issue counters
`define IFQ_PERF_W 32

`endif

// File: ifq_pkg.sv
`default_nettype none

package ifq_pkg;

    // one queued instruction with its fetch address
    typedef struct packed {
        // address of this instruction
        logic [31:0] pc;
        // raw instruction word
        logic [31:0] inst;
    } inst_entry_t;

    // one fetch response, an aligned pair of words
    typedef struct packed {
        // address of the first wanted word
        // bit 2 set means only word1 is wanted
        logic [31:0] pc;
        // word at the 8-byte aligned address
        logic [31:0] word0;
        // word at that address plus 4
        logic [31:0] word1;
    } fetch_resp_t;

    // what decode sees each cycle
    typedef struct packed {
        // older instruction, issues first
        inst_entry_t master;
        // younger instruction, only with the master
        inst_entry_t slave;
        logic        master_valid;
        logic        slave_valid;
        // pre-decoded from the master opcode
        logic        master_is_branch;
    } issue_pair_t;

endpackage

`default_nettype wire

// File: fetch_align.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifq_settings.svh"

module fetch_align (
    input  wire logic                clk,
    input  wire logic                fifo_rst,
    input  wire logic                fetch_valid,
    input  wire ifq_pkg::fetch_resp_t fetch_resp,
    output logic                     fetch_ready,
    input  wire logic                flush,
    input  wire logic                room_for_pair,
    output logic                     wr_en1,
    output logic                     wr_en2,
    output ifq_pkg::inst_entry_t     wr_entry1,
    output ifq_pkg::inst_entry_t     wr_entry2
);

    import ifq_pkg::*;

    logic                   accept;
    logic                   aligned;
    // last cycle's response, for the stall check
    fetch_resp_t            resp_q;
    logic                   stalled_q;
    // responses taken since reset
    logic [`IFQ_PERF_W-1:0] accepted_cnt;
    // response moved while it was being held off
    logic                   resp_changed;

    // always reserve room for a full pair, redirect blocks intake
    assign fetch_ready = room_for_pair && !flush;
    assign accept      = fetch_valid && fetch_ready;

    // pc bit 2 clear means both words are wanted
    assign aligned = !fetch_resp.pc[2];

    // older write first
    assign wr_en1 = accept;
    // second write only for an aligned pair
    assign wr_en2 = accept && aligned;

    always_comb begin
        // entry 1 starts at the requested pc in both cases
        wr_entry1.pc   = fetch_resp.pc;
        wr_entry1.inst = aligned ? fetch_resp.word0 : fetch_resp.word1;
        // entry 2 is the upper word of an aligned pair
        wr_entry2.pc   = fetch_resp.pc + 32'd4;
        wr_entry2.inst = fetch_resp.word1;
    end

    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            accepted_cnt <= '0;
            stalled_q    <= 1'b0;
        end else begin
            if (accept) begin
                accepted_cnt <= accepted_cnt + `IFQ_PERF_W'(1);
            end
            // held off by a full ring only, a redirect may replace the response
            stalled_q <= fetch_valid && !room_for_pair && !flush;
        end
    end

    // sampled every cycle
    always_ff @(posedge clk) begin
        resp_q <= fetch_resp;
    end

    // fetch must keep the response stable until it is taken
    assign resp_changed = stalled_q && fetch_valid && !flush && (fetch_resp != resp_q);

endmodule

`default_nettype wire

// File: inst_queue.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifq_settings.svh"

module inst_queue (
    input  wire logic                 clk,
    input  wire logic                 fifo_rst,
    input  wire logic                 flush,
    input  wire logic                 slot_pending,
    input  wire logic                 wr_en1,
    input  wire logic                 wr_en2,
    input  wire ifq_pkg::inst_entry_t wr_entry1,
    input  wire ifq_pkg::inst_entry_t wr_entry2,
    input  wire logic                 pop1,
    input  wire logic                 pop2,
    output ifq_pkg::inst_entry_t      head_entry0,
    output ifq_pkg::inst_entry_t      head_entry1,
    output logic [`IFQ_CNT_W-1:0]     count,
    output logic                      room_for_pair,
    output logic                      slot_held
);

    import ifq_pkg::*;

    // highest count that still leaves two free entries
    localparam int unsigned ROOM_MAX = `IFQ_DEPTH - 2;

    // instruction ring
    inst_entry_t            ring [`IFQ_DEPTH];

    logic [`IFQ_PTR_W-1:0]  wr_ptr;
    logic [`IFQ_PTR_W-1:0]  wr_ptr_plus1;
    logic [`IFQ_PTR_W-1:0]  rd_ptr;
    logic [`IFQ_PTR_W-1:0]  rd_ptr_plus1;
    logic [`IFQ_CNT_W-1:0]  count_q;

    // saved delay slot across a redirect
    inst_entry_t            hold_entry;
    logic                   held_q;

    // pops that consume ring entries
    logic                   ring_pop1;
    logic                   ring_pop2;

    // entries written and read this cycle, 0 to 2
    logic [1:0]             wr_num;
    logic [1:0]             rd_num;

    // keep the delay slot when its branch already left
    logic                   capture;

    assign wr_ptr_plus1 = wr_ptr + `IFQ_PTR_W'(1);
    assign rd_ptr_plus1 = rd_ptr + `IFQ_PTR_W'(1);

    // held entry is served first, the ring waits behind it
    assign ring_pop1 = pop1 && !held_q;
    // slave always comes from the ring
    assign ring_pop2 = pop2;

    assign wr_num = 2'(wr_en1) + 2'(wr_en2);
    assign rd_num = 2'(ring_pop1) + 2'(ring_pop2);

    // branch gone, slot still here and not taken now
    assign capture = flush && slot_pending && !pop1;

    // ring storage
    // wr_en2 only comes with wr_en1 so the pair lands back to back
    always_ff @(posedge clk) begin
        if (wr_en1) begin
            ring[wr_ptr] <= wr_entry1;
        end
        if (wr_en2) begin
            ring[wr_ptr_plus1] <= wr_entry2;
        end
    end

    // write pointer
    always_ff @(posedge clk) begin
        if (fifo_rst || flush) begin
            wr_ptr <= '0;
        end else begin
            wr_ptr <= wr_ptr + `IFQ_PTR_W'(wr_num);
        end
    end

    // read pointer
    always_ff @(posedge clk) begin
        if (fifo_rst || flush) begin
            rd_ptr <= '0;
        end else begin
            rd_ptr <= rd_ptr + `IFQ_PTR_W'(rd_num);
        end
    end

    // occupancy from writes and pops in the same cycle
    // pops are qualified upstream, never below zero
    always_ff @(posedge clk) begin
        if (fifo_rst || flush) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + `IFQ_CNT_W'(wr_num) - `IFQ_CNT_W'(rd_num);
        end
    end

    // delay slot hold flag
    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            held_q <= 1'b0;
        end else if (flush) begin
            // any other redirect drops everything
            held_q <= capture;
        end else if (pop1) begin
            // held slot issued
            held_q <= 1'b0;
        end
    end

    // current master, which may itself be the held slot
    always_ff @(posedge clk) begin
        if (capture) begin
            hold_entry <= head_entry0;
        end
    end

    // heads
    assign head_entry0 = held_q ? hold_entry : ring[rd_ptr];
    assign head_entry1 = ring[rd_ptr_plus1];

    assign count         = count_q;
    assign room_for_pair = (count_q <= `IFQ_CNT_W'(ROOM_MAX));
    assign slot_held     = held_q;

endmodule

`default_nettype wire

// File: issue_stage.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifq_settings.svh"

module issue_stage (
    input  wire logic                 clk,
    input  wire logic                 fifo_rst,
    input  wire ifq_pkg::inst_entry_t head_entry0,
    input  wire ifq_pkg::inst_entry_t head_entry1,
    input  wire logic [`IFQ_CNT_W-1:0] count,
    input  wire logic                 slot_held,
    input  wire logic                 take1,
    input  wire logic                 take2,
    output logic                      pop1,
    output logic                      pop2,
    output logic                      slot_pending,
    output ifq_pkg::issue_pair_t      issue,
    output logic [`IFQ_PERF_W-1:0]    master_issued,
    output logic [`IFQ_PERF_W-1:0]    slave_issued
);

    import ifq_pkg::*;

    // primary opcodes
    localparam logic [5:0] OP_SPECIAL = 6'b000000;
    localparam logic [5:0] OP_REGIMM  = 6'b000001;
    localparam logic [5:0] OP_J       = 6'b000010;
    localparam logic [5:0] OP_JAL     = 6'b000011;
    localparam logic [5:0] OP_BEQ     = 6'b000100;
    localparam logic [5:0] OP_BNE     = 6'b000101;
    localparam logic [5:0] OP_BLEZ    = 6'b000110;
    localparam logic [5:0] OP_BGTZ    = 6'b000111;
    // special function codes
    localparam logic [5:0] FN_JR      = 6'b001000;
    localparam logic [5:0] FN_JALR    = 6'b001001;

    logic master_valid;
    logic slave_valid;
    logic master_branch;

    // anything that owns a delay slot
    function automatic logic is_branch(input inst_entry_t e);
        logic [5:0] op;
        logic [5:0] fn;
        op = e.inst[31:26];
        fn = e.inst[5:0];
        case (op)
            OP_REGIMM, OP_J, OP_JAL, OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ: begin
                is_branch = 1'b1;
            end
            OP_SPECIAL: begin
                is_branch = (fn == FN_JR) || (fn == FN_JALR);
            end
            default: begin
                is_branch = 1'b0;
            end
        endcase
    endfunction

    // held slot counts as a master even with an empty ring
    assign master_valid = (count != '0) || slot_held;
    // held slot always issues alone
    assign slave_valid  = (count >= `IFQ_CNT_W'(2)) && !slot_held;

    // only meaningful on a valid master
    assign master_branch = master_valid && is_branch(head_entry0);

    // pops already qualified, the queue trusts them
    assign pop1 = take1 && master_valid;
    assign pop2 = pop1 && take2 && slave_valid;

    always_comb begin
        issue.master           = head_entry0;
        issue.slave            = head_entry1;
        issue.master_valid     = master_valid;
        issue.slave_valid      = slave_valid;
        issue.master_is_branch = master_branch;
    end

    // next master is a delay slot when a branch left alone
    // branch with its slave means the slot went too
    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            slot_pending <= 1'b0;
        end else if (pop1) begin
            slot_pending <= master_branch && !pop2;
        end
    end

    // issue statistics
    always_ff @(posedge clk) begin
        if (fifo_rst) begin
            master_issued <= '0;
            slave_issued  <= '0;
        end else begin
            if (pop1) begin
                master_issued <= master_issued + `IFQ_PERF_W'(1);
            end
            if (pop2) begin
                slave_issued <= slave_issued + `IFQ_PERF_W'(1);
            end
        end
    end

endmodule

`default_nettype wire

// File: ifq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifq_settings.svh"

module ifq_top (
    input  wire logic                 clk,
    input  wire logic                 fifo_rst,
    input  wire logic                 fetch_valid,
    input  wire ifq_pkg::fetch_resp_t fetch_resp,
    output logic                      fetch_ready,
    input  wire logic                 flush,
    input  wire logic                 take1,
    input  wire logic                 take2,
    output ifq_pkg::issue_pair_t      issue,
    output logic                      in_delayslot,
    output logic [`IFQ_PERF_W-1:0]    master_issued,
    output logic [`IFQ_PERF_W-1:0]    slave_issued
);

    import ifq_pkg::*;

    // align to queue
    logic                  wr_en1;
    logic                  wr_en2;
    inst_entry_t           wr_entry1;
    inst_entry_t           wr_entry2;
    logic                  room_for_pair;

    // queue to issue
    inst_entry_t           head_entry0;
    inst_entry_t           head_entry1;
    logic [`IFQ_CNT_W-1:0] count;
    logic                  slot_held;
    logic                  pop1;
    logic                  pop2;

    fetch_align u_fetch_align (
        .clk           (clk),
        .fifo_rst      (fifo_rst),
        .fetch_valid   (fetch_valid),
        .fetch_resp    (fetch_resp),
        .fetch_ready   (fetch_ready),
        .flush         (flush),
        .room_for_pair (room_for_pair),
        .wr_en1        (wr_en1),
        .wr_en2        (wr_en2),
        .wr_entry1     (wr_entry1),
        .wr_entry2     (wr_entry2)
    );

    // delay-slot flag from issue also steers the flush hold
    inst_queue u_inst_queue (
        .clk           (clk),
        .fifo_rst      (fifo_rst),
        .flush         (flush),
        .slot_pending  (in_delayslot),
        .wr_en1        (wr_en1),
        .wr_en2        (wr_en2),
        .wr_entry1     (wr_entry1),
        .wr_entry2     (wr_entry2),
        .pop1          (pop1),
        .pop2          (pop2),
        .head_entry0   (head_entry0),
        .head_entry1   (head_entry1),
        .count         (count),
        .room_for_pair (room_for_pair),
        .slot_held     (slot_held)
    );

    issue_stage u_issue_stage (
        .clk           (clk),
        .fifo_rst      (fifo_rst),
        .head_entry0   (head_entry0),
        .head_entry1   (head_entry1),
        .count         (count),
        .slot_held     (slot_held),
        .take1         (take1),
        .take2         (take2),
        .pop1          (pop1),
        .pop2          (pop2),
        .slot_pending  (in_delayslot),
        .issue         (issue),
        .master_issued (master_issued),
        .slave_issued  (slave_issued)
    );

endmodule

`default_nettype wire

// File: ifq_sva.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifq_settings.svh"

module ifq_sva (
    input wire logic                  clk,
    input wire logic                  fifo_rst,
    input wire logic [`IFQ_CNT_W-1:0] count,
    input wire logic                  room_for_pair,
    input wire logic                  wr_en1,
    input wire logic                  wr_en2,
    input wire logic                  pop1,
    input wire logic                  pop2,
    input wire logic                  slot_held
);

    // occupancy stays inside the ring
    a_count_max: assert property (@(posedge clk) disable iff (fifo_rst)
        count <= `IFQ_CNT_W'(`IFQ_DEPTH))
        else $error("queue count above depth");

    // intake only with two free entries
    a_write_room: assert property (@(posedge clk) disable iff (fifo_rst)
        (wr_en1 || wr_en2) |-> room_for_pair)
        else $error("write while room_for_pair low");

    a_pop_order: assert property (@(posedge clk) disable iff (fifo_rst)
        pop2 |-> pop1)
        else $error("pop2 without pop1");

    // held slot issues alone, slave never valid so never popped
    a_held_alone: assert property (@(posedge clk) disable iff (fifo_rst)
        slot_held |-> !pop2)
        else $error("slave popped while delay slot held");

endmodule

bind inst_queue ifq_sva u_ifq_sva (
    .clk           (clk),
    .fifo_rst      (fifo_rst),
    .count         (count),
    .room_for_pair (room_for_pair),
    .wr_en1        (wr_en1),
    .wr_en2        (wr_en2),
    .pop1          (pop1),
    .pop2          (pop2),
    .slot_held     (slot_held)
);

`default_nettype wire

// File: tb_ifq_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifq_settings.svh"

module tb_ifq_top;

    import ifq_pkg::*;

    // cycles of all phases, for the watchdog
    localparam int RUN_CYCLES = 10 + 8 + 24 + 300 + 35 + 20 + 300 + 5;

    logic                   clk;
    logic                   fifo_rst;
    logic                   fetch_valid;
    fetch_resp_t            fetch_resp;
    logic                   fetch_ready;
    logic                   flush;
    logic                   take1;
    logic                   take2;
    issue_pair_t            issue;
    logic                   in_delayslot;
    logic [`IFQ_PERF_W-1:0] master_issued;
    logic [`IFQ_PERF_W-1:0] slave_issued;

    // reference model state, always the state the DUT holds now
    inst_entry_t mq[$];
    inst_entry_t m_hold;
    logic        m_held;
    logic        m_pending;
    int unsigned m_master;
    int unsigned m_slave;
    // fetch responses taken since reset
    int unsigned m_accepted;
    // response refused last cycle, must be offered again unchanged
    logic        resp_waiting;

    int unsigned seed = 48205;
    int          errors = 0;
    int          checks = 0;
    string       test_name = "reset";

    ifq_top DUT (
        .clk           (clk),
        .fifo_rst      (fifo_rst),
        .fetch_valid   (fetch_valid),
        .fetch_resp    (fetch_resp),
        .fetch_ready   (fetch_ready),
        .flush         (flush),
        .take1         (take1),
        .take2         (take2),
        .issue         (issue),
        .in_delayslot  (in_delayslot),
        .master_issued (master_issued),
        .slave_issued  (slave_issued)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    function automatic int unsigned lcg();
        seed = seed * 32'd1103515245 + 32'd12345;
        return seed;
    endfunction

    // true with a chance of p percent
    function automatic logic pct(input int p);
        return int'((lcg() >> 8) % 100) < p;
    endfunction

    // random word, about a quarter forced to a branch or jump
    function automatic logic [31:0] rand_inst();
        logic [31:0] w;
        logic [31:0] sel;
        w = lcg();
        sel = lcg();
        if (sel[29:28] == 2'b00) begin
            w[31:26] = 6'(sel[26:24]);
            // opcode 0 becomes jr or jalr
            if (sel[26:24] == 3'd0) begin
                w[5:0] = sel[20] ? 6'h09 : 6'h08;
            end
        end
        return w;
    endfunction

    // regimm, j, jal, beq, bne, blez, bgtz are opcodes 1 to 7
    function automatic logic ref_branch(input logic [31:0] w);
        if (w[31:26] >= 6'd1 && w[31:26] <= 6'd7) begin
            return 1'b1;
        end
        return (w[31:26] == 6'd0) && (w[5:0] == 6'h08 || w[5:0] == 6'h09);
    endfunction

    // expected issue slots from the model
    function automatic issue_pair_t model_issue();
        issue_pair_t e;
        e = '0;
        e.master_valid = (mq.size() > 0) || m_held;
        e.slave_valid  = (mq.size() >= 2) && !m_held;
        if (m_held) begin
            e.master = m_hold;
        end else if (mq.size() > 0) begin
            e.master = mq[0];
        end
        if (mq.size() > 1) begin
            e.slave = mq[1];
        end
        e.master_is_branch = e.master_valid && ref_branch(e.master.inst);
        return e;
    endfunction

    task automatic model_reset();
        mq.delete();
        m_held       = 1'b0;
        m_pending    = 1'b0;
        m_master     = 0;
        m_slave      = 0;
        m_accepted   = 0;
        resp_waiting = 1'b0;
    endtask

    // advance the model over the coming edge
    task automatic model_step(input issue_pair_t e, input logic ready_exp);
        logic        p1;
        logic        p2;
        inst_entry_t ent;
        p1 = take1 && e.master_valid;
        p2 = p1 && take2 && e.slave_valid;
        resp_waiting = fetch_valid && !ready_exp;
        if (flush) begin
            // branch gone and slot not taken now, keep the slot
            m_held = m_pending && !p1;
            if (m_held) begin
                m_hold = e.master;
            end
            mq.delete();
        end else begin
            if (p1 && m_held) begin
                m_held = 1'b0;
            end else if (p1) begin
                void'(mq.pop_front());
            end
            if (p2) begin
                void'(mq.pop_front());
            end
            if (fetch_valid && ready_exp) begin
                m_accepted++;
                ent.pc   = fetch_resp.pc;
                ent.inst = fetch_resp.pc[2] ? fetch_resp.word1 : fetch_resp.word0;
                mq.push_back(ent);
                if (!fetch_resp.pc[2]) begin
                    ent.pc   = fetch_resp.pc + 32'd4;
                    ent.inst = fetch_resp.word1;
                    mq.push_back(ent);
                end
            end
        end
        if (p1) begin
            m_pending = e.master_is_branch && !p2;
        end
        m_master += 32'(p1);
        m_slave  += 32'(p2);
    endtask

    task automatic check_val(input string what, input logic [63:0] exp, input logic [63:0] act);
        checks++;
        if (exp !== act) begin
            errors++;
            $display("ERR %s %s expected %h actual %h", test_name, what, exp, act);
        end
    endtask

    // compare in mid-cycle, inputs and outputs both settled
    always @(negedge clk) begin
        issue_pair_t e;
        logic        ready_exp;
        if (fifo_rst) begin
            model_reset();
        end else begin
            e = model_issue();
            ready_exp = (mq.size() <= `IFQ_DEPTH - 2) && !flush;
            check_val("fetch_ready", 64'(ready_exp), 64'(fetch_ready));
            check_val("in_delayslot", 64'(m_pending), 64'(in_delayslot));
            check_val("master_valid", 64'(e.master_valid), 64'(issue.master_valid));
            check_val("slave_valid", 64'(e.slave_valid), 64'(issue.slave_valid));
            if (e.master_valid) begin
                check_val("master", 64'(e.master), 64'(issue.master));
                check_val("master_is_branch", 64'(e.master_is_branch),
                          64'(issue.master_is_branch));
            end
            if (e.slave_valid) begin
                check_val("slave", 64'(e.slave), 64'(issue.slave));
            end
            check_val("master_issued", 64'(m_master), 64'(master_issued));
            check_val("slave_issued", 64'(m_slave), 64'(slave_issued));
            check_val("accepted_cnt", 64'(m_accepted),
                      64'(DUT.u_fetch_align.accepted_cnt));
            if (DUT.u_fetch_align.resp_changed) begin
                errors++;
                $display("%s: fetch response changed while it was held off", test_name);
            end
            model_step(e, ready_exp);
        end
    end

    task automatic set_inputs(input logic fv, input logic [31:0] pc, input logic [31:0] w0,
                              input logic [31:0] w1, input logic t1, input logic t2,
                              input logic fl);
        fetch_valid      = fv;
        fetch_resp.pc    = pc;
        fetch_resp.word0 = w0;
        fetch_resp.word1 = w1;
        take1            = t1;
        take2            = t2;
        flush            = fl;
    endtask

    // one directed cycle, driven just after the edge
    task automatic drive(input logic fv, input logic [31:0] pc, input logic [31:0] w0,
                         input logic [31:0] w1, input logic t1, input logic t2,
                         input logic fl);
        @(posedge clk);
        #1;
        set_inputs(fv, pc, w0, w1, t1, t2, fl);
    endtask

    task automatic run_random(input int n, input int pv, input int pt1, input int pt2,
                              input int pfl);
        fetch_resp_t r;
        logic        fv;
        logic        fl;
        for (int i = 0; i < n; i++) begin
            @(posedge clk);
            #1;
            r  = fetch_resp;
            fv = 1'b1;
            // a refused response stays on the bus
            if (!resp_waiting) begin
                r.pc    = (lcg() & 32'h0000_fffc) | 32'h0040_0000;
                r.word0 = rand_inst();
                r.word1 = rand_inst();
                fv      = pct(pv);
            end
            fl = pct(pfl);
            // slot not fetched yet, nothing to save
            if (fl && m_pending && mq.size() == 0 && !m_held) begin
                fl = 1'b0;
            end
            set_inputs(fv, r.pc, r.word0, r.word1, pct(pt1), pct(pt2), fl);
        end
    endtask

    initial begin
        fifo_rst = 1'b1;
        set_inputs(1'b0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0);
        repeat (10) @(posedge clk);
        #1;
        fifo_rst = 1'b0;

        // aligned pair then single upper word, issued in order
        test_name = "align";
        drive(1'b1, 32'h0000_1000, 32'h2401_0001, 32'h2402_0002, 1'b0, 1'b0, 1'b0);
        drive(1'b1, 32'h0000_2004, 32'h2403_0003, 32'h2404_0004, 1'b0, 1'b0, 1'b0);
        drive(1'b0, 32'h0, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0);
        drive(1'b0, 32'h0, 32'h0, 32'h0, 1'b1, 1'b1, 1'b0);
        drive(1'b0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0);

        // no pops, fetch must stall near full
        test_name = "backpressure";
        run_random(24, 100, 0, 0, 0);
        check_val("fill_level", 64'(mq.size()), 64'(DUT.count));

        test_name = "random_pop";
        run_random(300, 60, 70, 60, 0);

        test_name = "reset_mid";
        run_random(30, 80, 30, 30, 0);
        @(posedge clk);
        #1;
        fifo_rst = 1'b1;
        set_inputs(1'b0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0);
        repeat (3) @(posedge clk);
        #1;
        fifo_rst = 1'b0;

        // beq alone, then its slot
        test_name = "delay_slot";
        drive(1'b1, 32'h0000_3000, 32'h1000_0003, 32'h2405_0005, 1'b0, 1'b0, 1'b0);
        drive(1'b0, 32'h0, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0);
        drive(1'b0, 32'h0, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0);
        // bne with its slot in one pair
        drive(1'b1, 32'h0000_3008, 32'h1400_0002, 32'h2406_0006, 1'b0, 1'b0, 1'b0);
        drive(1'b0, 32'h0, 32'h0, 32'h0, 1'b1, 1'b1, 1'b0);
        // jr alone, redirect before its slot issues
        drive(1'b1, 32'h0000_3010, 32'h03e0_0008, 32'h2407_0007, 1'b0, 1'b0, 1'b0);
        drive(1'b0, 32'h0, 32'h0, 32'h0, 1'b1, 1'b0, 1'b0);
        drive(1'b0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b1);
        drive(1'b1, 32'h0000_4000, 32'h2408_0008, 32'h2409_0009, 1'b0, 1'b0, 1'b0);
        drive(1'b0, 32'h0, 32'h0, 32'h0, 1'b1, 1'b1, 1'b0);
        drive(1'b0, 32'h0, 32'h0, 32'h0, 1'b1, 1'b1, 1'b0);

        test_name = "flush_random";
        run_random(300, 70, 60, 50, 6);

        drive(1'b0, 32'h0, 32'h0, 32'h0, 1'b0, 1'b0, 1'b0);
        repeat (3) @(negedge clk);
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("SIMULATION PASSED");
        end else begin
            $display("SIMULATION FAILED");
        end
        $finish;
    end

    initial begin
        #(RUN_CYCLES * 10 + 1000);
        $display("timeout: the tests did not complete in the expected time");
        $display("SIMULATION FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// File: ifq.f
+incdir+.
ifq_pkg.sv
fetch_align.sv
inst_queue.sv
issue_stage.sv
ifq_top.sv
ifq_sva.sv
tb_ifq_top.sv

// File: Makefile
SIM  := obj_dir/Vtb_ifq_top
SRCS := $(filter %.sv,$(shell cat ifq.f))

.PHONY: run clean

run: $(SIM)
	./$(SIM) > sim.log 2>&1; cat sim.log
	@if grep -q "SIMULATION FAILED" sim.log; then exit 1; fi
	@grep -q "SIMULATION PASSED" sim.log

$(SIM): ifq.f ifq_settings.svh $(SRCS)
	verilator --binary --timing --assert -f ifq.f --top-module tb_ifq_top \
		-Mdir obj_dir -o Vtb_ifq_top

clean:
	rm -rf obj_dir sim.log
